//--- hw/mipsPkg.sv
/*
 * MIPS subset CPU shared definitions
 * Data widths, instruction encodings, control states and the
 * request bundle passed from the requesters to the bus arbiter
 */
package mipsPkg;

    typedef logic [31:0] word_t;    // Data word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [4:0]  regIdx_t;  // GPR index
    typedef logic [3:0]  byteEn_t;  // One bit per byte lane

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,   // R-type, decoded by funct
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LB      = 6'd32,
        OP_LH      = 6'd33,
        OP_LW      = 6'd35,
        OP_LBU     = 6'd36,
        OP_LHU     = 6'd37,
        OP_SB      = 6'd40,
        OP_SH      = 6'd41,
        OP_SW      = 6'd43
    } opcode_t;

    // Function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [1:0] {
        FETCH,  // Waiting on instruction word
        EXEC,   // Single decode/execute cycle
        MEM,    // Load or store on the bus
        HALT    // Stopped until reset
    } cpuState_t;

    // Data access kind handed to the load/store unit
    typedef enum logic [2:0] {
        LW, LH, LHU, LB, LBU, SW, SH, SB
    } memOp_t;

    // One bus request, 70 bits
    typedef struct packed {
        logic    valid;   // Held until the matching done pulse
        logic    write;   // 0 read, 1 write
        addr_t   addr;
        word_t   wdata;
        byteEn_t byteEn;
    } busReq_t;

    localparam addr_t   resetVector = 32'hBFC0_0000;
    localparam addr_t   haltAddr    = 32'h0000_0000;  // Jump here to stop
    localparam int      numRegs     = 32;
    localparam regIdx_t v0Idx       = 5'd2;

endpackage

//--- hw/regFile.sv
/*
 * General purpose register file
 * 32 x 32, two combinational reads, one clocked write, $zero fixed
 */
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t rsIdx,
    input  regIdx_t rtIdx,
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData,
    output word_t   rsData,
    output word_t   rtData,
    output word_t   registerV0
);

    word_t regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) regs[i] <= '0;
        end else if (wrEn && (wrIdx != '0)) begin  // $zero never written
            regs[wrIdx] <= wrData;
        end
    end

    assign rsData     = (rsIdx == '0) ? '0 : regs[rsIdx];
    assign rtData     = (rtIdx == '0) ? '0 : regs[rtIdx];
    assign registerV0 = regs[v0Idx];  // Debug view of $v0

endmodule

//--- hw/instrFetch.sv
/*
 * Instruction fetcher
 * Owns the PC and the instruction register and raises a word
 * read at the PC each time the core enters FETCH
 */
`timescale 1ns/1ps

module instrFetch import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    fetchEn,     // Core is in FETCH
    input  logic    pcLoad,
    input  addr_t   nextPc,
    input  logic    fetchDone,
    input  word_t   readdata,
    output busReq_t fetchReq,
    output word_t   instr,
    output addr_t   pc,
    output logic    instrValid
);

    logic fetching;  // Request outstanding on the arbiter

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= resetVector;
            fetching <= 1'b0;
        end else begin
            if (pcLoad) pc <= nextPc;
            // Done wins, so the same word is never requested twice
            if (fetchDone) fetching <= 1'b0;
            else if (fetchEn) fetching <= 1'b1;
        end
    end

    // Instruction register loads on fetch completion
    always_ff @(posedge clk) begin
        if (fetchDone) instr <= readdata;
    end

    always_comb begin
        fetchReq.valid  = fetching;
        fetchReq.write  = 1'b0;       // Fetches only read
        fetchReq.addr   = pc;
        fetchReq.wdata  = '0;
        fetchReq.byteEn = 4'b1111;    // Whole word
    end

    assign instrValid = fetchDone;

    // Targets come from PC+4, imm<<2 and the JR register
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- hw/busArbiter.sv
/*
 * Avalon-MM bus arbiter
 * Data requests beat fetch requests, a stalled grant stays locked
 * until the transfer completes, then the owner gets a done pulse
 */
`timescale 1ns/1ps

module busArbiter import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  busReq_t fetchReq,
    input  busReq_t dataReq,
    input  logic    waitrequest,
    output addr_t   address,
    output logic    read,
    output logic    write,
    output word_t   writedata,
    output byteEn_t byteenable,
    output logic    fetchDone,
    output logic    dataDone
);

    logic    locked;      // Transfer stalled last cycle
    logic    grantReg;    // 1 = data side owned the bus
    logic    grantData;
    busReq_t sel;
    logic    xferDone;

    // Held grant while stalled and fresh priority otherwise
    assign grantData = locked ? grantReg : dataReq.valid;
    assign sel       = grantData ? dataReq : fetchReq;

    assign read       = sel.valid && !sel.write;
    assign write      = sel.valid && sel.write;
    assign address    = sel.addr;
    assign writedata  = sel.wdata;
    assign byteenable = sel.byteEn;

    assign xferDone  = sel.valid && !waitrequest;  // Only waitrequest test in the CPU
    assign fetchDone = xferDone && !grantData;
    assign dataDone  = xferDone && grantData;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked   <= 1'b0;
            grantReg <= 1'b0;
        end else begin
            locked   <= sel.valid && waitrequest;
            grantReg <= grantData;
        end
    end

    // One instruction in flight, so fetch and data never ask together
    oneRequester: assert property (@(posedge clk) disable iff (reset)
        !(fetchReq.valid && dataReq.valid));

    // Requester holds its level and the lock keeps the same owner
    addrStable: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && (read || write));

endmodule

//--- hw/loadStoreUnit.sv
/*
 * Load/store unit
 * Captures one access per memStart, aligns it to a word transfer
 * with byte enables, and extracts and extends load data
 */
`timescale 1ns/1ps

module loadStoreUnit import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    memStart,
    input  memOp_t  memOp,
    input  addr_t   memAddr,
    input  word_t   storeData,
    input  logic    dataDone,
    input  word_t   readdata,
    output busReq_t dataReq,
    output word_t   loadResult,
    output logic    memDone
);

    logic       pending;     // Request waiting for dataDone
    memOp_t     opQ;
    addr_t      addrQ;
    word_t      storeQ;
    logic [4:0] laneShift;   // Byte offset times 8
    word_t      shifted;

    always_ff @(posedge clk) begin
        if (reset) pending <= 1'b0;
        else if (dataDone) pending <= 1'b0;
        else if (memStart) pending <= 1'b1;
    end

    // Access payload
    always_ff @(posedge clk) begin
        if (memStart) begin
            opQ    <= memOp;
            addrQ  <= memAddr;
            storeQ <= storeData;
        end
    end

    assign laneShift = {addrQ[1:0], 3'b000};

    always_comb begin
        dataReq.valid = pending;
        dataReq.write = opQ inside {SW, SH, SB};
        dataReq.addr  = {addrQ[31:2], 2'b00};  // Bus sees word addresses only
        case (opQ)
            SB: begin
                dataReq.byteEn = byteEn_t'(4'b0001 << addrQ[1:0]);
                dataReq.wdata  = {24'd0, storeQ[7:0]} << laneShift;
            end
            SH: begin
                dataReq.byteEn = byteEn_t'(4'b0011 << addrQ[1:0]);
                dataReq.wdata  = {16'd0, storeQ[15:0]} << laneShift;
            end
            default: begin  // Words and all loads
                dataReq.byteEn = 4'b1111;
                dataReq.wdata  = storeQ;
            end
        endcase
    end

    // Bring the selected lane down to bit 0
    assign shifted = readdata >> laneShift;

    always_comb begin
        case (opQ)
            LB:      loadResult = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     loadResult = {24'd0, shifted[7:0]};
            LH:      loadResult = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     loadResult = {16'd0, shifted[15:0]};
            default: loadResult = readdata;  // LW
        endcase
    end

    assign memDone = dataDone;

    // Core computes the address, program keeps halves aligned
    halfAligned: assert property (@(posedge clk) disable iff (reset)
        dataReq.valid && (opQ inside {LH, LHU, SH}) |-> !addrQ[0]);

endmodule

//--- hw/execCore.sv
/*
 * Execution core
 * FETCH/EXEC/MEM/HALT sequencer with decode, ALU, branch and
 * jump resolution, and register write-back
 */
`timescale 1ns/1ps

module execCore import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  word_t   instr,
    input  addr_t   pc,
    input  logic    instrValid,
    input  word_t   loadResult,
    input  logic    memDone,
    input  word_t   rsData,
    input  word_t   rtData,
    output logic    active,
    output logic    fetchEn,
    output logic    pcLoad,
    output addr_t   nextPc,
    output logic    memStart,
    output memOp_t  memOp,
    output addr_t   memAddr,
    output word_t   storeData,
    output regIdx_t rsIdx,
    output regIdx_t rtIdx,
    output logic    wrEn,
    output regIdx_t wrIdx,
    output word_t   wrData
);

    cpuState_t  state;
    opcode_t    opcode;
    funct_t     funct;
    logic [4:0] shamt;
    word_t      immSext, immZext;
    addr_t      pcPlus4, branchTarget, target;
    word_t      aluResult;
    logic       aluWrite, isJump, isLoad, isStore, halt;

    // Field split
    assign opcode  = opcode_t'(instr[31:26]);
    assign funct   = funct_t'(instr[5:0]);
    assign shamt   = instr[10:6];
    assign rsIdx   = instr[25:21];
    assign rtIdx   = instr[20:16];
    assign immSext = {{16{instr[15]}}, instr[15:0]};
    assign immZext = {16'd0, instr[15:0]};

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immSext[29:0], 2'b00};

    always_comb begin
        aluResult = '0;
        aluWrite  = 1'b0;
        wrIdx     = rtIdx;          // I-type and loads
        target    = pcPlus4;        // Fall through
        isJump    = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        memOp     = LW;
        case (opcode)
            OP_SPECIAL: begin
                wrIdx    = instr[15:11];  // rd
                aluWrite = 1'b1;
                case (funct)
                    FN_ADDU: aluResult = rsData + rtData;
                    FN_SUBU: aluResult = rsData - rtData;
                    FN_AND:  aluResult = rsData & rtData;
                    FN_OR:   aluResult = rsData | rtData;
                    FN_XOR:  aluResult = rsData ^ rtData;
                    FN_SLT:  aluResult = {31'd0, $signed(rsData) < $signed(rtData)};
                    FN_SLTU: aluResult = {31'd0, rsData < rtData};
                    FN_SLL:  aluResult = rtData << shamt;
                    FN_SRL:  aluResult = rtData >> shamt;
                    FN_SRA:  aluResult = word_t'($signed(rtData) >>> shamt);
                    FN_JR: begin
                        aluWrite = 1'b0;
                        isJump   = 1'b1;
                        target   = rsData;
                    end
                    default: aluWrite = 1'b0;  // Unknown funct is a no-op
                endcase
            end
            OP_J: begin
                isJump = 1'b1;
                target = {pcPlus4[31:28], instr[25:0], 2'b00};
            end
            OP_BEQ: if (rsData == rtData) target = branchTarget;
            OP_BNE: if (rsData != rtData) target = branchTarget;
            OP_ADDIU: begin aluWrite = 1'b1; aluResult = rsData + immSext; end
            OP_SLTI:  begin aluWrite = 1'b1; aluResult = {31'd0, $signed(rsData) < $signed(immSext)}; end
            OP_SLTIU: begin aluWrite = 1'b1; aluResult = {31'd0, rsData < immSext}; end
            OP_ANDI:  begin aluWrite = 1'b1; aluResult = rsData & immZext; end
            OP_ORI:   begin aluWrite = 1'b1; aluResult = rsData | immZext; end
            OP_XORI:  begin aluWrite = 1'b1; aluResult = rsData ^ immZext; end
            OP_LUI:   begin aluWrite = 1'b1; aluResult = {instr[15:0], 16'd0}; end
            OP_LW:    begin isLoad = 1'b1; memOp = LW; end
            OP_LH:    begin isLoad = 1'b1; memOp = LH; end
            OP_LHU:   begin isLoad = 1'b1; memOp = LHU; end
            OP_LB:    begin isLoad = 1'b1; memOp = LB; end
            OP_LBU:   begin isLoad = 1'b1; memOp = LBU; end
            OP_SW:    begin isStore = 1'b1; memOp = SW; end
            OP_SH:    begin isStore = 1'b1; memOp = SH; end
            OP_SB:    begin isStore = 1'b1; memOp = SB; end
            default: ;  // Unknown opcode, just advance
        endcase
    end

    assign halt      = isJump && (target == haltAddr);
    assign memAddr   = rsData + immSext;
    assign storeData = rtData;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH: if (instrValid) state <= EXEC;
                EXEC: begin
                    if (isLoad || isStore) state <= MEM;
                    else if (halt) state <= HALT;
                    else state <= FETCH;
                end
                MEM: if (memDone) state <= FETCH;
                default: state <= HALT;  // Only reset leaves HALT
            endcase
        end
    end

    assign active   = (state != HALT);
    assign fetchEn  = (state == FETCH);
    assign memStart = (state == EXEC) && (isLoad || isStore);
    assign pcLoad   = ((state == EXEC) && !(isLoad || isStore) && !halt)
                    || ((state == MEM) && memDone);
    assign nextPc   = (state == MEM) ? pcPlus4 : target;
    // Loads write in the memDone cycle
    assign wrEn     = ((state == EXEC) && aluWrite) || ((state == MEM) && memDone && isLoad);
    assign wrData   = (state == MEM) ? loadResult : aluResult;

endmodule

//--- hw/mipsCpuBus.sv
/*
 * MIPS subset CPU, Avalon-MM master
 * Multicycle core with a fetcher and a load/store unit sharing
 * the single memory port through a bus arbiter
 */
`timescale 1ns/1ps

module mipsCpuBus import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    output logic    active,
    output word_t   registerV0,

    // Avalon-MM master
    output addr_t   address,
    output logic    write,
    output logic    read,
    input  logic    waitrequest,
    output word_t   writedata,
    output byteEn_t byteenable,
    input  word_t   readdata
);

    busReq_t fetchReq;
    busReq_t dataReq;
    logic    fetchDone;
    logic    dataDone;

    // Core to fetcher
    logic    fetchEn;
    logic    pcLoad;
    addr_t   nextPc;
    word_t   instr;
    addr_t   pc;
    logic    instrValid;

    // Core to load/store unit
    logic    memStart;
    memOp_t  memOp;
    addr_t   memAddr;
    word_t   storeData;
    word_t   loadResult;
    logic    memDone;

    // Register file ports
    regIdx_t rsIdx;
    regIdx_t rtIdx;
    logic    wrEn;
    regIdx_t wrIdx;
    word_t   wrData;
    word_t   rsData;
    word_t   rtData;

    instrFetch i_instrFetch (
        .clk, .reset, .fetchEn, .pcLoad, .nextPc, .fetchDone, .readdata,
        .fetchReq, .instr, .pc, .instrValid
    );

    busArbiter i_busArbiter (
        .clk, .reset, .fetchReq, .dataReq, .waitrequest,
        .address, .read, .write, .writedata, .byteenable, .fetchDone, .dataDone
    );

    loadStoreUnit i_loadStoreUnit (
        .clk, .reset, .memStart, .memOp, .memAddr, .storeData, .dataDone, .readdata,
        .dataReq, .loadResult, .memDone
    );

    execCore i_execCore (
        .clk, .reset, .instr, .pc, .instrValid, .loadResult, .memDone, .rsData, .rtData,
        .active, .fetchEn, .pcLoad, .nextPc, .memStart, .memOp, .memAddr, .storeData,
        .rsIdx, .rtIdx, .wrEn, .wrIdx, .wrData
    );

    regFile i_regFile (
        .clk, .reset, .rsIdx, .rtIdx, .wrEn, .wrIdx, .wrData,
        .rsData, .rtData, .registerV0
    );

endmodule

//--- verif/tbAvalonMem.sv
/*
 * Avalon-MM slave memory model
 * Sparse word storage, zero-latency reads, 0 to 3 random
 * waitrequest cycles per transfer and a count of accepted writes
 */
`timescale 1ns/1ps

module tbAvalonMem import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  addr_t   address,
    input  logic    read,
    input  logic    write,
    input  word_t   writedata,
    input  byteEn_t byteenable,
    output logic    waitrequest,
    output word_t   readdata
);

    word_t mem [addr_t];   // Keyed by word address
    int    waitCnt;
    int    writeCount;     // Accepted write transfers

    // Unloaded words read back a pattern of their address
    function automatic word_t peek(addr_t a, int version);
        return mem.exists(a) ? mem[a] : (a ^ 32'h5EED_F00D);
    endfunction

    // Version argument re-evaluates after every write
    assign readdata = read ? peek(address, writeCount) : '0;

    task automatic loadWord(addr_t a, word_t d);
        mem[a] = d;
    endtask

    initial begin
        waitrequest = 1'b0;
        waitCnt     = 0;
        writeCount  = 0;
    end

    always @(posedge clk) begin
        word_t w;
        int    n;
        if (reset) begin
            waitCnt     <= 0;
            waitrequest <= 1'b0;
        end else if ((read || write) && !waitrequest) begin
            if (write) begin
                w = peek(address, writeCount);
                for (int b = 0; b < 4; b++)
                    if (byteenable[b]) w[8*b +: 8] = writedata[8*b +: 8];
                mem[address] = w;
                writeCount++;
            end
            n = $urandom % 4;          // Stall length of the next transfer
            waitCnt     <= n;
            waitrequest <= (n != 0);
        end else if (read || write) begin
            waitCnt     <= waitCnt - 1;
            waitrequest <= (waitCnt > 1);
        end
    end

endmodule

//--- verif/tbMipsCpuBus.sv
/*
 * Testbench for the MIPS subset CPU
 * Random program at the reset vector, instruction-set model
 * checked on every bus transfer, halt and final v0
 */
`timescale 1ns/1ps

module tbMipsCpuBus import mipsPkg::*;;

    localparam int    numInstr   = 150;
    localparam int    lastIdx    = numInstr + 2;            // JR $0 slot
    localparam int    resetCycles = 4;
    localparam int    maxCycles  = (numInstr + 3) * 10 + resetCycles + 20;
    localparam addr_t dataBase   = 32'h1000_0100;           // 256-byte window

    logic clk, reset, active, read, write, waitrequest;
    word_t registerV0, writedata, readdata;
    addr_t address;
    byteEn_t byteenable;

    word_t prog [lastIdx + 1];
    word_t dmem [64];             // Model data window
    word_t mreg [numRegs];
    addr_t mPc;
    logic  halted, expData, expWrite, stalled;
    addr_t expAddr, pAddr;
    byteEn_t expBe, pBe;
    word_t expWdata, pData;
    int    numStores, cycleCount;

    mipsCpuBus i_dut (.clk, .reset, .active, .registerV0, .address, .write, .read,
        .waitrequest, .writedata, .byteenable, .readdata);
    tbAvalonMem i_mem (.clk, .reset, .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFailure(string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(string what, word_t got, word_t exp);
        if (got !== exp)
            reportFailure($sformatf("[FAIL] %0d ns %s: got %h, expected %h",
                                    $time, what, got, exp));
    endtask

    task automatic checkAddr(string what, addr_t got, addr_t exp);
        if (got !== exp)
            reportFailure($sformatf("[FAIL] %0d ns %s: got %h, expected %h",
                                    $time, what, got, exp));
    endtask

    task automatic checkByteEn(string what, byteEn_t got, byteEn_t exp);
        if (got !== exp)
            reportFailure($sformatf("[FAIL] %0d ns %s: got %b, expected %b",
                                    $time, what, got, exp));
    endtask

    // Destination never touches $zero or the base register r8
    function automatic regIdx_t destReg();
        return ($urandom % 3 == 0) ? v0Idx : regIdx_t'(1 + $urandom % 7);
    endfunction

    function automatic word_t genInstr(int idx);
        logic [5:0] fns [10] = '{33, 35, 36, 37, 38, 42, 43, 0, 2, 3};
        logic [5:0] imms [7] = '{9, 10, 11, 12, 13, 14, 15};
        logic [5:0] lds [5]  = '{35, 33, 37, 32, 36};
        logic [5:0] sts [3]  = '{43, 41, 40};
        logic [5:0] op, fn;
        logic [15:0] off;
        int k, span, t;
        k    = $urandom % 10;
        span = (lastIdx - idx < 4) ? lastIdx - idx : 4;   // Stay inside the program
        off  = 16'($urandom % 256);
        case (k)
            0: begin
                fn = fns[$urandom % 10];
                if (fn <= 3) return {6'd0, 5'd0, 5'($urandom % 9), destReg(), 5'($urandom), fn};
                return {6'd0, 5'($urandom % 9), 5'($urandom % 9), destReg(), 5'd0, fn};
            end
            3: begin
                op = lds[$urandom % 5];
                if (op == 35) off[1:0] = 2'b00;
                else if (op inside {33, 37}) off[0] = 1'b0;
                return {op, 5'd8, destReg(), off};
            end
            4: begin
                op = sts[$urandom % 3];
                if (op == 43) off[1:0] = 2'b00;
                else if (op == 41) off[0] = 1'b0;
                return {op, 5'd8, 5'($urandom % 9), off};
            end
            5: return {6'(4 + $urandom % 2), 5'($urandom % 9), 5'($urandom % 9),
                       16'($urandom % span)};   // Forward branch
            6: begin
                t = idx + 1 + $urandom % span;
                return {6'd2, 26'((resetVector + 4 * t) >> 2)};
            end
            default: return {imms[$urandom % 7], 5'($urandom % 9), destReg(), 16'($urandom)};
        endcase
    endfunction

    // Executes the instruction at mPc and sets up any data transfer
    task automatic step();
        word_t ins, a, b, se, ze, res, w;
        addr_t pc4, nxt, ea;
        regIdx_t dst;
        logic wr;
        int sh;
        int n, lo;
        ins = prog[(mPc - resetVector) >> 2];
        a   = mreg[ins[25:21]];
        b   = mreg[ins[20:16]];
        se  = {{16{ins[15]}}, ins[15:0]};
        ze  = {16'd0, ins[15:0]};
        pc4 = mPc + 4;
        nxt = pc4;
        ea  = a + se;
        sh  = 8 * ea[1:0];
        w   = dmem[ea[7:2]] >> sh;
        dst = ins[20:16];
        wr  = 1'b1;
        res = '0;
        case (opcode_t'(ins[31:26]))
            OP_SPECIAL: begin
                dst = ins[15:11];
                case (funct_t'(ins[5:0]))
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                    FN_SLTU: res = (a < b) ? 1 : 0;
                    FN_SLL:  res = b << ins[10:6];
                    FN_SRL:  res = b >> ins[10:6];
                    FN_SRA:  res = $signed(b) >>> ins[10:6];
                    default: begin   // JR
                        wr  = 1'b0;
                        nxt = a;
                    end
                endcase
            end
            OP_J: begin
                wr  = 1'b0;
                nxt = {pc4[31:28], ins[25:0], 2'b00};
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (ins[31:26] == OP_BEQ)) nxt = pc4 + (se << 2);
            end
            OP_ADDIU: res = a + se;
            OP_SLTI:  res = ($signed(a) < $signed(se)) ? 1 : 0;
            OP_SLTIU: res = (a < se) ? 1 : 0;
            OP_ANDI:  res = a & ze;
            OP_ORI:   res = a | ze;
            OP_XORI:  res = a ^ ze;
            OP_LUI:   res = {ins[15:0], 16'd0};
            OP_LW:    res = dmem[ea[7:2]];
            OP_LH:    res = {{16{w[15]}}, w[15:0]};
            OP_LHU:   res = {16'd0, w[15:0]};
            OP_LB:    res = {{24{w[7]}}, w[7:0]};
            OP_LBU:   res = {24'd0, w[7:0]};
            default: begin   // Stores
                wr       = 1'b0;
                n        = (ins[31:26] == OP_SW) ? 4 : (ins[31:26] == OP_SH) ? 2 : 1;
                lo       = ea[1:0];
                expBe    = 4'b0000;
                expWdata = '0;
                // Byte j of rt lands in lane lo + j
                for (int i = 0; i < 4; i++) begin
                    expBe[i] = (i >= lo) && (i < lo + n);
                    if (expBe[i]) begin
                        expWdata[8*i +: 8]      = b[8*(i - lo) +: 8];
                        dmem[ea[7:2]][8*i +: 8] = b[8*(i - lo) +: 8];
                    end
                end
                numStores++;
            end
        endcase
        if (ins[31]) begin   // Loads and stores go on the bus
            expData  = 1'b1;
            expWrite = ins[29];
            expAddr  = {ea[31:2], 2'b00};
        end
        if (wr && dst != 0) mreg[dst] = res;
        if (nxt == haltAddr) halted = 1'b1;
        mPc = nxt;
    endtask

    // Bus monitor sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        if (!reset) begin
            if (read && write) reportFailure("read and write were high together");
            if (halted && (read || write)) reportFailure("bus transfer seen after the halt jump");
            if (stalled) begin
                if (!(read || write)) reportFailure("request dropped while waitrequest was high");
                checkAddr("stalled address", address, pAddr);
                checkByteEn("stalled byteenable", byteenable, pBe);
                checkWord("stalled writedata", writedata, pData);
            end
            if ((read || write) && !waitrequest) begin
                if (expData) begin
                    if (write !== expWrite) reportFailure("data transfer has the wrong direction");
                    checkAddr("data address", address, expAddr);
                    if (write) begin
                        checkByteEn("store byteenable", byteenable, expBe);
                        checkWord("store writedata", writedata, expWdata);
                    end
                    expData = 1'b0;
                end else begin
                    if (write) reportFailure("write seen where a fetch was expected");
                    checkAddr("fetch address", address, mPc);
                    checkWord("registerV0", registerV0, mreg[v0Idx]);
                    step();
                end
            end
            stalled = (read || write) && waitrequest;
            pAddr   = address;
            pBe     = byteenable;
            pData   = writedata;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > maxCycles) reportFailure("Timeout: CPU did not halt in time");
    end

    initial begin
        void'($urandom(53392));
        reset = 1'b1;
        {halted, expData, expWrite, stalled} = '0;
        numStores  = 0;
        cycleCount = 0;
        mPc = resetVector;
        foreach (mreg[i]) mreg[i] = '0;
        foreach (dmem[i]) begin
            dmem[i] = $urandom;
            i_mem.loadWord(dataBase + 4 * i, dmem[i]);
        end
        prog[0] = {OP_LUI, 5'd0, 5'd8, dataBase[31:16]};
        prog[1] = {OP_ORI, 5'd8, 5'd8, dataBase[15:0]};
        for (int i = 2; i < lastIdx; i++) prog[i] = genInstr(i);
        prog[lastIdx] = {6'd0, 20'd0, FN_JR};   // Jump to 0 halts
        foreach (prog[i]) i_mem.loadWord(resetVector + 4 * i, prog[i]);
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        wait (halted);
        repeat (5) @(posedge clk);
        @(negedge clk);
        if (active !== 1'b0) reportFailure("active still high after the halt jump");
        checkWord("final registerV0", registerV0, mreg[v0Idx]);
        if (i_mem.writeCount != numStores) reportFailure("memory saw a wrong number of writes");
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- mipsCpuBus.f
hw/mipsPkg.sv
hw/regFile.sv
hw/instrFetch.sv
hw/busArbiter.sv
hw/loadStoreUnit.sv
hw/execCore.sv
hw/mipsCpuBus.sv
verif/tbAvalonMem.sv
verif/tbMipsCpuBus.sv

//--- Bender.yml
package:
  name: mipsCpuBus

sources:
  - files:
      - hw/mipsPkg.sv
      - hw/regFile.sv
      - hw/instrFetch.sv
      - hw/busArbiter.sv
      - hw/loadStoreUnit.sv
      - hw/execCore.sv
      - hw/mipsCpuBus.sv
  - target: test
    files:
      - verif/tbAvalonMem.sv
      - verif/tbMipsCpuBus.sv
